/* files.f */
rtl/vcp_cfg_pkg.sv
rtl/vcp_isa_pkg.sv
rtl/vcp_if.sv
rtl/vcp_lane_alu.sv
rtl/vcp_pipe_buf.sv
rtl/vcp_ctrl.sv
rtl/vcp_issue.sv
rtl/vcp_exec.sv
rtl/vcp_top.sv
tb/tb_vcp.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the vector co-processor testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_vcp -f files.f -o tb_vcp
./obj_dir/tb_vcp | tee sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
	exit 1
fi
if ! grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
	exit 1
fi

/* tb/tb_vcp.sv */
/*
 * Directed testbench for the vector co-processor
 * Drives single instructions through the core-side ports and checks
 * results against a register model
 */

`timescale 1ns/1ps

module tb_vcp;
	import vcp_cfg_pkg::*;
	import vcp_isa_pkg::*;

	localparam int WAIT_LIMIT = 100; // Cycles per handshake wait

	logic      clk_i;
	logic      rstn_i;
	logic      valid_i;
	logic      pop_o;
	vop_e      op_i;
	vreg_idx_t vd_i;
	vreg_idx_t vs1_i;
	vreg_idx_t vs2_i;
	elem_t     rs1_i;
	elem_t     rs2_i;
	logic      valid_o;
	elem_t     result_o;
	logic      idle_o;

	vec_t  model [NUM_VREGS]; // Expected register file
	int    errors;
	int    checks;
	int    pop_cnt;           // Cycles with pop_o high
	int    vld_cnt;           // Cycles with valid_o high
	elem_t scratch;

	vcp_top DUT (
		.clk_i   (clk_i),
		.rstn_i  (rstn_i),
		.valid_i (valid_i),
		.pop_o   (pop_o),
		.op_i    (op_i),
		.vd_i    (vd_i),
		.vs1_i   (vs1_i),
		.vs2_i   (vs2_i),
		.rs1_i   (rs1_i),
		.rs2_i   (rs2_i),
		.valid_o (valid_o),
		.result_o(result_o),
		.idle_o  (idle_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i; // 4 ns period
	end

	// Pulse counters, sampled mid-cycle
	always @(negedge clk_i) begin
		if (pop_o) pop_cnt++;
		if (valid_o) vld_cnt++;
	end

	//////////////////////////////////////////////////
	// Checks and run control
	//////////////////////////////////////////////////
	task automatic check_elem(input string name, input elem_t got, input elem_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic end_run();
		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////
	function automatic elem_t lane_of(vec_t v, int k);
		return v[k*ELEM_W +: ELEM_W];
	endfunction

	// Applies one instruction to the model, returns the expected result_o
	task automatic model_step(input vop_e op, input vreg_idx_t vd, input vreg_idx_t vs1,
			input vreg_idx_t vs2, input elem_t rs1, output elem_t exp_res);
		vec_t  src_a;
		vec_t  src_b;
		vec_t  dst;
		elem_t a;
		elem_t b;
		elem_t y;
		int    idx;
		src_a = model[vs1];
		src_b = model[vs2];
		dst   = '0;
		for (int k = 0; k < LANES; k++) begin
			a = lane_of(src_a, k);
			b = lane_of(src_b, k);
			case (op)
				VOP_VADD_VV: y = a + b; // Wraps mod 2^32
				VOP_VSUB_VV: y = a - b;
				VOP_VAND_VV: y = a & b;
				VOP_VOR_VV:  y = a | b;
				VOP_VXOR_VV: y = a ^ b;
				VOP_VADD_VX: y = a + rs1;
				VOP_VMV_VX:  y = rs1;
				default:     y = a;
			endcase
			dst[k*ELEM_W +: ELEM_W] = y;
		end
		if (op == VOP_VMV_XS) begin
			idx     = int'(rs1 % LANES); // No register write
			exp_res = lane_of(src_a, idx);
		end else begin
			model[vd] = dst;
			exp_res   = lane_of(dst, 0);
		end
	endtask

	//////////////////////////////////////////////////
	// Handshake waits
	//////////////////////////////////////////////////
	task automatic wait_pop(output int lat);
		logic seen;
		seen = 1'b0;
		lat  = 0;
		while (!seen && lat < WAIT_LIMIT) begin
			@(negedge clk_i);
			seen = pop_o;
			lat++;
		end
		if (!seen) begin
			errors++;
			$display("Timeout: pop_o never rose within %0d cycles", WAIT_LIMIT);
		end
	endtask

	task automatic wait_done();
		logic seen;
		int   n;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < WAIT_LIMIT) begin
			@(negedge clk_i);
			seen = valid_o;
			n++;
		end
		if (!seen) begin
			errors++;
			$display("Timeout: valid_o never rose within %0d cycles", WAIT_LIMIT);
		end
	endtask

	// One instruction from offer to completion, result checked against model
	task automatic exec_instr(input vop_e op, input vreg_idx_t vd, input vreg_idx_t vs1,
			input vreg_idx_t vs2, input elem_t rs1, output elem_t res);
		elem_t exp_res;
		int    pop_before;
		int    vld_before;
		int    lat;
		model_step(op, vd, vs1, vs2, rs1, exp_res);
		@(posedge clk_i);
		pop_before = pop_cnt;
		vld_before = vld_cnt;
		valid_i <= 1'b1;
		op_i    <= op;
		vd_i    <= vd;
		vs1_i   <= vs1;
		vs2_i   <= vs2;
		rs1_i   <= rs1;
		rs2_i   <= $urandom(); // Ignored by every op
		wait_pop(lat);
		check_bit("pop_o one cycle after valid_i", lat == 2, 1'b1);
		@(posedge clk_i);
		valid_i <= 1'b0;
		wait_done();
		res = result_o;
		check_elem("result_o", result_o, exp_res);
		@(negedge clk_i);
		check_bit("valid_o", valid_o, 1'b0); // Single-cycle pulse
		check_bit("idle_o", idle_o, 1'b1);
		check_elem("result_o held", result_o, exp_res);
		@(posedge clk_i);
		check_bit("one pop_o pulse", (pop_cnt - pop_before) == 1, 1'b1);
		check_bit("one valid_o pulse", (vld_cnt - vld_before) == 1, 1'b1);
	endtask

	// Reads all lanes of a register back through extract
	task automatic check_lanes(input vreg_idx_t vs);
		elem_t res;
		for (int k = 0; k < LANES; k++) begin
			exec_instr(VOP_VMV_XS, '0, vs, '0, elem_t'(k), res);
			check_elem("extracted lane", res, lane_of(model[vs], k));
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////
	task automatic test_reset_state();
		elem_t res;
		@(negedge clk_i);
		check_bit("idle_o after reset", idle_o, 1'b1);
		check_bit("valid_o after reset", valid_o, 1'b0);
		check_bit("pop_o after reset", pop_o, 1'b0);
		for (int r = 0; r < NUM_VREGS; r++) begin
			exec_instr(VOP_VMV_XS, '0, vreg_idx_t'(r), '0, $urandom(), res);
			check_elem("register after reset", res, '0);
		end
	endtask

	task automatic test_splat();
		elem_t s;
		elem_t res;
		for (int r = 1; r < NUM_VREGS; r += 2) begin
			s = $urandom();
			exec_instr(VOP_VMV_VX, vreg_idx_t'(r), '0, '0, s, res);
			for (int k = 0; k < LANES; k++) begin
				exec_instr(VOP_VMV_XS, '0, vreg_idx_t'(r), '0, elem_t'(k), res);
				check_elem("splat lane", res, s);
			end
		end
	endtask

	task automatic test_vv_ops();
		vop_e ops [5];
		ops = '{VOP_VADD_VV, VOP_VSUB_VV, VOP_VAND_VV, VOP_VOR_VV, VOP_VXOR_VV};
		for (int round = 0; round < 2; round++) begin
			exec_instr(VOP_VMV_VX, 3'd1, '0, '0, $urandom(), scratch);
			exec_instr(VOP_VMV_VX, 3'd2, '0, '0, $urandom(), scratch);
			foreach (ops[i]) begin
				exec_instr(ops[i], 3'd3, 3'd1, 3'd2, $urandom(), scratch);
				check_lanes(3'd3);
			end
		end
	endtask

	task automatic test_vadd_vx();
		elem_t res;
		exec_instr(VOP_VMV_VX, 3'd4, '0, '0, 32'hFFFFFFFF, res);
		exec_instr(VOP_VADD_VX, 3'd5, 3'd4, '0, 32'h1, res);
		check_elem("wrapped sum", res, 32'h0);
		check_elem("result_o is lane 0", res, lane_of(model[5], 0));
		exec_instr(VOP_VADD_VX, 3'd6, 3'd4, '0, $urandom(), res);
		exec_instr(VOP_VADD_VX, 3'd6, 3'd6, '0, 32'hFFFFFFF0, res); // vd same as vs1
		check_elem("result_o is lane 0", res, lane_of(model[6], 0));
		check_lanes(3'd5);
		check_lanes(3'd6);
	endtask

	// Each instruction reads the previous destination
	task automatic test_dependent_chain();
		exec_instr(VOP_VMV_VX, 3'd0, '0, '0, $urandom(), scratch);
		exec_instr(VOP_VADD_VX, 3'd1, 3'd0, '0, $urandom(), scratch);
		exec_instr(VOP_VSUB_VV, 3'd2, 3'd1, 3'd0, '0, scratch);
		exec_instr(VOP_VXOR_VV, 3'd3, 3'd2, 3'd1, '0, scratch);
		exec_instr(VOP_VOR_VV, 3'd3, 3'd3, 3'd0, '0, scratch);
		exec_instr(VOP_VAND_VV, 3'd4, 3'd3, 3'd2, '0, scratch);
		exec_instr(VOP_VADD_VV, 3'd4, 3'd4, 3'd4, '0, scratch);
		check_lanes(3'd4);
	endtask

	initial begin
		rstn_i  = 1'b0;
		valid_i = 1'b0;
		op_i    = VOP_VADD_VV;
		vd_i    = '0;
		vs1_i   = '0;
		vs2_i   = '0;
		rs1_i   = '0;
		rs2_i   = '0;
		errors  = 0;
		checks  = 0;
		pop_cnt = 0;
		vld_cnt = 0;
		for (int r = 0; r < NUM_VREGS; r++) begin
			model[r] = '0;
		end
		void'($urandom(32'hb54f));
		repeat (16) @(posedge clk_i);
		rstn_i <= 1'b1;
		test_reset_state();
		test_splat();
		test_vv_ops();
		test_vadd_vx();
		test_dependent_chain();
		end_run();
	end

endmodule

/* rtl/vcp_top.sv */
/*
 * Vector co-processor top level
 * Controller, buffer, issue and execute with plain core-side ports
 */

`timescale 1ns/1ps

module vcp_top (
	input  logic                   clk_i,
	input  logic                   rstn_i,
	input  logic                   valid_i,  // Instruction from core
	output logic                   pop_o,    // Instruction consumed
	input  vcp_isa_pkg::vop_e      op_i,
	input  vcp_cfg_pkg::vreg_idx_t vd_i,
	input  vcp_cfg_pkg::vreg_idx_t vs1_i,
	input  vcp_cfg_pkg::vreg_idx_t vs2_i,
	input  vcp_cfg_pkg::elem_t     rs1_i,
	input  vcp_cfg_pkg::elem_t     rs2_i,
	output logic                   valid_o,  // Completion pulse
	output vcp_cfg_pkg::elem_t     result_o,
	output logic                   idle_o    // Whole unit idle
);

	vcp_instr_if instr_c2b (); // Controller to buffer
	vcp_instr_if instr_b2i (); // Buffer to issue
	vcp_exec_if  ex_if ();
	vcp_wb_if    wb_if ();

	logic ctrl_idle;
	logic buf_empty;
	logic issue_idle;
	logic exec_idle;

	assign idle_o = ctrl_idle & buf_empty & issue_idle & exec_idle;

	//////////////////////////////////////////////////
	// Stages
	//////////////////////////////////////////////////
	vcp_ctrl u_ctrl (
		.clk_i   (clk_i),
		.rstn_i  (rstn_i),
		.valid_i (valid_i),
		.pop_o   (pop_o),
		.op_i    (op_i),
		.vd_i    (vd_i),
		.vs1_i   (vs1_i),
		.vs2_i   (vs2_i),
		.rs1_i   (rs1_i),
		.rs2_i   (rs2_i),
		.instr   (instr_c2b.src),
		.wb      (wb_if.snk),
		.valid_o (valid_o),
		.result_o(result_o),
		.idle_o  (ctrl_idle)
	);

	vcp_pipe_buf u_buf (
		.clk_i  (clk_i),
		.rstn_i (rstn_i),
		.in     (instr_c2b.dst),
		.out    (instr_b2i.src),
		.empty_o(buf_empty)
	);

	vcp_issue u_issue (
		.clk_i (clk_i),
		.rstn_i(rstn_i),
		.instr (instr_b2i.dst),
		.ex    (ex_if.src),
		.wb    (wb_if.snk),
		.idle_o(issue_idle)
	);

	vcp_exec u_exec (
		.clk_i (clk_i),
		.rstn_i(rstn_i),
		.ex    (ex_if.dst),
		.wb    (wb_if.src),
		.idle_o(exec_idle)
	);

endmodule

/* rtl/vcp_exec.sv */
/*
 * Execute unit
 * Four lane ALUs, a lane result stage and a writeback register
 */

`timescale 1ns/1ps

module vcp_exec (
	input  logic    clk_i,
	input  logic    rstn_i,
	vcp_exec_if.dst ex, // From issue
	vcp_wb_if.src   wb, // Writeback broadcast
	output logic    idle_o
);
	import vcp_cfg_pkg::*;
	import vcp_isa_pkg::*;

	vec_t      lane_y;  // All lane results
	logic      take;    // Transfer from issue
	logic      s1_valid;
	vop_e      s1_op;
	vreg_idx_t s1_vd;
	lane_idx_t s1_idx;  // Extract lane
	vec_t      s1_data;
	elem_t     s1_result;

	//////////////////////////////////////////////////
	// Lane array
	//////////////////////////////////////////////////
	for (genvar k = 0; k < LANES; k++) begin : g_lane
		vcp_lane_alu u_alu (
			.op_i    (ex.op),
			.a_i     (ex.opa[k*ELEM_W +: ELEM_W]),
			.b_i     (ex.opb[k*ELEM_W +: ELEM_W]),
			.scalar_i(ex.scalar),
			.y_o     (lane_y[k*ELEM_W +: ELEM_W])
		);
	end

	// Writeback has no back-pressure, so neither stage ever holds
	assign ex.ready = 1'b1;
	assign take     = ex.valid && ex.ready;

	// Extract picks the indexed lane, all others report lane 0
	assign s1_result = (s1_op == VOP_VMV_XS) ? s1_data[s1_idx*ELEM_W +: ELEM_W]
	                                         : s1_data[ELEM_W-1:0];

	// Stage valids
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			s1_valid <= 1'b0;
			wb.en    <= 1'b0;
		end else begin
			s1_valid <= take;
			wb.en    <= s1_valid; // One pulse per instruction
		end
	end

	// Stage payloads
	always_ff @(posedge clk_i) begin
		if (take) begin
			s1_op   <= ex.op;
			s1_vd   <= ex.vd;
			s1_idx  <= ex.scalar[LANE_IDX_W-1:0]; // rs1 mod LANES
			s1_data <= lane_y;
		end
		if (s1_valid) begin
			wb.vd     <= s1_vd;
			wb.data   <= s1_data; // Extract carries vs1 back unchanged
			wb.result <= s1_result;
		end
	end

	assign idle_o = !s1_valid && !wb.en;

endmodule

/* rtl/vcp_issue.sv */
/*
 * Issue stage
 * Vector register file, busy scoreboard, hazard check and
 * registered operand read ahead of the execute unit
 */

`timescale 1ns/1ps

module vcp_issue (
	input  logic     clk_i,
	input  logic     rstn_i,
	vcp_instr_if.dst instr, // From buffer
	vcp_exec_if.src  ex,    // To execute
	vcp_wb_if.snk    wb,    // Register writeback
	output logic     idle_o
);
	import vcp_cfg_pkg::*;
	import vcp_isa_pkg::*;

	vec_t                 rf [NUM_VREGS]; // Vector register file
	logic [NUM_VREGS-1:0] busy;           // Pending write per register

	logic      pend_valid; // Instruction waiting to launch
	vop_e      pend_op;
	vreg_idx_t pend_vd;
	vreg_idx_t pend_vs1;
	vreg_idx_t pend_vs2;
	elem_t     pend_scalar;

	vreg_idx_t eff_vd;  // Register the result goes to
	vreg_idx_t rd_a;    // Read address port A
	vreg_idx_t rd_b;    // Read address port B
	vec_t      opa_q;
	vec_t      opb_q;
	logic      accept;
	logic      hazard;
	logic      launch;

	// Register read with writeback bypass
	function automatic vec_t read_vreg(vreg_idx_t idx);
		if (wb.en && wb.vd == idx) return wb.data;
		return rf[idx];
	endfunction

	//////////////////////////////////////////////////
	// Hazard check and handshakes
	//////////////////////////////////////////////////
	// Extract writes vs1 back unchanged, so vs1 is its destination
	assign eff_vd = (pend_op == VOP_VMV_XS) ? pend_vs1 : pend_vd;
	assign hazard = busy[pend_vs1] || busy[pend_vs2] || busy[eff_vd];

	assign ex.valid    = pend_valid && !hazard;
	assign launch      = ex.valid && ex.ready;
	assign instr.ready = !pend_valid || launch; // Refill as the slot leaves
	assign accept      = instr.valid && instr.ready;

	// New arrival reads its own sources, a stalled one rereads
	assign rd_a = accept ? instr.vs1 : pend_vs1;
	assign rd_b = accept ? instr.vs2 : pend_vs2;

	// Control, scoreboard and register file
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			pend_valid <= 1'b0;
			busy       <= '0;
			for (int i = 0; i < NUM_VREGS; i++) begin
				rf[i] <= '0;
			end
		end else begin
			if (accept) begin
				pend_valid <= 1'b1;
			end else if (launch) begin
				pend_valid <= 1'b0;
			end
			if (wb.en) begin
				rf[wb.vd]   <= wb.data;
				busy[wb.vd] <= 1'b0;
			end
			if (launch) busy[eff_vd] <= 1'b1; // Set wins over same-cycle clear
		end
	end

	// Pending instruction and operand registers
	always_ff @(posedge clk_i) begin
		if (accept) begin
			pend_op     <= instr.op;
			pend_vd     <= instr.vd;
			pend_vs1    <= instr.vs1;
			pend_vs2    <= instr.vs2;
			pend_scalar <= instr.scalar;
		end
		opa_q <= read_vreg(rd_a);
		opb_q <= read_vreg(rd_b);
	end

	assign ex.op     = pend_op;
	assign ex.vd     = eff_vd;
	assign ex.opa    = opa_q;
	assign ex.opb    = opb_q;
	assign ex.scalar = pend_scalar;

	assign idle_o = !pend_valid && (busy == '0);

endmodule

/* rtl/vcp_ctrl.sv */
/*
 * Sequencing controller
 * Takes one instruction from the core, pushes it into the pipeline
 * and reports completion with the scalar result
 */

`timescale 1ns/1ps

module vcp_ctrl (
	input  logic                  clk_i,
	input  logic                  rstn_i,
	input  logic                  valid_i,  // Instruction offered by core
	output logic                  pop_o,    // Instruction taken
	input  vcp_isa_pkg::vop_e     op_i,
	input  vcp_cfg_pkg::vreg_idx_t vd_i,
	input  vcp_cfg_pkg::vreg_idx_t vs1_i,
	input  vcp_cfg_pkg::vreg_idx_t vs2_i,
	input  vcp_cfg_pkg::elem_t    rs1_i,    // Scalar operand
	input  vcp_cfg_pkg::elem_t    rs2_i,    // Kept for bus compatibility, no op reads it
	vcp_instr_if.src              instr,    // To pipeline buffer
	vcp_wb_if.snk                 wb,       // Completion from execute
	output logic                  valid_o,  // Completion pulse
	output vcp_cfg_pkg::elem_t    result_o,
	output logic                  idle_o
);
	import vcp_cfg_pkg::*;
	import vcp_isa_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE, // Wait for core
		S_PUSH, // Offer to buffer
		S_BUSY, // Wait for writeback
		S_DONE  // Signal completion
	} state_e;

	state_e    state;
	vop_e      op_q;
	vreg_idx_t vd_q;
	vreg_idx_t vs1_q;
	vreg_idx_t vs2_q;
	elem_t     rs1_q;

	//////////////////////////////////////////////////
	// Sequencing FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			state    <= S_IDLE;
			pop_o    <= 1'b0;
			result_o <= '0;
		end else begin
			pop_o <= 1'b0; // Single-cycle pulse
			case (state)
				S_IDLE: begin
					if (valid_i) begin
						pop_o <= 1'b1;
						state <= S_PUSH;
					end
				end
				S_PUSH: begin
					if (instr.ready) state <= S_BUSY; // Buffer took it
				end
				S_BUSY: begin
					if (wb.en) begin
						result_o <= wb.result;
						state    <= S_DONE;
					end
				end
				S_DONE: begin
					state <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Instruction latch
	always_ff @(posedge clk_i) begin
		if (state == S_IDLE && valid_i) begin
			op_q  <= op_i;
			vd_q  <= vd_i;
			vs1_q <= vs1_i;
			vs2_q <= vs2_i;
			rs1_q <= rs1_i;
		end
	end

	assign instr.valid  = (state == S_PUSH); // Held until accepted
	assign instr.op     = op_q;
	assign instr.vd     = vd_q;
	assign instr.vs1    = vs1_q;
	assign instr.vs2    = vs2_q;
	assign instr.scalar = rs1_q;

	assign valid_o = (state == S_DONE);
	assign idle_o  = (state == S_IDLE);

endmodule

/* rtl/vcp_pipe_buf.sv */
/*
 * One-entry instruction buffer
 * Decouples the controller from the issue stage
 */

`timescale 1ns/1ps

module vcp_pipe_buf (
	input  logic clk_i,   // Clock
	input  logic rstn_i,  // Async reset, active low
	vcp_instr_if.dst in,  // From controller
	vcp_instr_if.src out, // To issue
	output logic empty_o  // No entry held
);

	logic full;  // Entry valid
	logic wr_en; // Write this cycle
	logic rd_en; // Read this cycle

	assign rd_en    = full && out.ready;
	assign in.ready = !full || out.ready; // Free, or being drained now
	assign wr_en    = in.valid && in.ready;

	assign out.valid = full;
	assign empty_o   = !full;

	// Occupancy
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			full <= 1'b0;
		end else if (wr_en) begin
			full <= 1'b1; // Write wins over a same-cycle read
		end else if (rd_en) begin
			full <= 1'b0;
		end
	end

	// Payload register
	always_ff @(posedge clk_i) begin
		if (wr_en) begin
			out.op     <= in.op;
			out.vd     <= in.vd;
			out.vs1    <= in.vs1;
			out.vs2    <= in.vs2;
			out.scalar <= in.scalar;
		end
	end

endmodule

/* rtl/vcp_lane_alu.sv */
/*
 * Integer lane ALU
 * One 32-bit element, combinational, wrapping arithmetic
 */

`timescale 1ns/1ps

module vcp_lane_alu (
	input  vcp_isa_pkg::vop_e  op_i,     // Operation
	input  vcp_cfg_pkg::elem_t a_i,      // vs1 element
	input  vcp_cfg_pkg::elem_t b_i,      // vs2 element
	input  vcp_cfg_pkg::elem_t scalar_i, // rs1
	output vcp_cfg_pkg::elem_t y_o
);
	import vcp_cfg_pkg::*;
	import vcp_isa_pkg::*;

	always_comb begin
		case (op_i)
			VOP_VADD_VV: y_o = a_i + b_i;
			VOP_VSUB_VV: y_o = a_i - b_i;
			VOP_VAND_VV: y_o = a_i & b_i;
			VOP_VOR_VV:  y_o = a_i | b_i;
			VOP_VXOR_VV: y_o = a_i ^ b_i;
			VOP_VADD_VX: y_o = a_i + scalar_i;
			VOP_VMV_VX:  y_o = scalar_i;  // Splat
			VOP_VMV_XS:  y_o = a_i;       // Pass through for extract
			default:     y_o = a_i;
		endcase
	end

endmodule

/* rtl/vcp_if.sv */
/*
 * Stage interfaces of the vector co-processor
 * Instruction hand-off, issue to execute, and writeback broadcast
 */

`timescale 1ns/1ps

// Decoded instruction with valid/ready handshake
interface vcp_instr_if;
	import vcp_cfg_pkg::*;
	import vcp_isa_pkg::*;

	logic      valid;  // Payload present
	logic      ready;  // Sink can take it
	vop_e      op;     // Operation
	vreg_idx_t vd;     // Destination register
	vreg_idx_t vs1;    // Source register 1
	vreg_idx_t vs2;    // Source register 2
	elem_t     scalar; // rs1 value

	modport src (output valid, op, vd, vs1, vs2, scalar, input ready);
	modport dst (input valid, op, vd, vs1, vs2, scalar, output ready);
endinterface

// Operands launched from issue into execute
interface vcp_exec_if;
	import vcp_cfg_pkg::*;
	import vcp_isa_pkg::*;

	logic      valid;
	logic      ready;
	vop_e      op;
	vreg_idx_t vd;     // Register to write back
	vec_t      opa;    // vs1 contents
	vec_t      opb;    // vs2 contents
	elem_t     scalar; // rs1 value, also extract index

	modport src (output valid, op, vd, opa, opb, scalar, input ready);
	modport dst (input valid, op, vd, opa, opb, scalar, output ready);
endinterface

// Writeback broadcast, one en pulse per retired instruction
interface vcp_wb_if;
	import vcp_cfg_pkg::*;

	logic      en;
	vreg_idx_t vd;
	vec_t      data;   // Full register value
	elem_t     result; // Scalar result for the core

	modport src (output en, vd, data, result);
	modport snk (input en, vd, data, result);
endinterface

/* rtl/vcp_isa_pkg.sv */
/*
 * Vector co-processor instruction set
 * Operation encoding shared by the controller, issue and execute stages
 */

package vcp_isa_pkg;

	//////////////////////////////////////////////////
	// Encoding
	//////////////////////////////////////////////////
	localparam int OP_W = 3; // Operation code width

	// Integer vector operations, coded 0 to 7
	typedef enum logic [OP_W-1:0] {
		VOP_VADD_VV = 3'd0, // vd[k] = vs1[k] + vs2[k]
		VOP_VSUB_VV = 3'd1, // vd[k] = vs1[k] - vs2[k]
		VOP_VAND_VV = 3'd2, // vd[k] = vs1[k] & vs2[k]
		VOP_VOR_VV  = 3'd3, // vd[k] = vs1[k] | vs2[k]
		VOP_VXOR_VV = 3'd4, // vd[k] = vs1[k] ^ vs2[k]
		VOP_VADD_VX = 3'd5, // vd[k] = vs1[k] + rs1
		VOP_VMV_VX  = 3'd6, // Splat rs1 into every lane
		VOP_VMV_XS  = 3'd7  // Scalar result = vs1[rs1 mod LANES]
	} vop_e;

	// Vector-vector group, vs2 is a real operand
	// Vector-scalar group, scalar goes to every lane
	// Extract has no register write

endpackage

/* rtl/vcp_cfg_pkg.sv */
/*
 * Vector co-processor datapath configuration
 * Lane count, element width, register count and the vector types
 * that are built from them
 */

package vcp_cfg_pkg;

	//////////////////////////////////////////////////
	// Datapath sizes
	//////////////////////////////////////////////////
	localparam int LANES     = 4;  // Active integer lanes
	localparam int ELEM_W    = 32; // Bits per lane element
	localparam int NUM_VREGS = 8;  // Architectural vector registers

	localparam int VREG_IDX_W = $clog2(NUM_VREGS); // Register number width
	localparam int LANE_IDX_W = $clog2(LANES);     // Lane number width

	//////////////////////////////////////////////////
	// Vector types
	//////////////////////////////////////////////////
	typedef logic [ELEM_W-1:0]       elem_t;     // One lane element
	typedef logic [LANES*ELEM_W-1:0] vec_t;      // Whole register, lane 0 in low bits
	typedef logic [VREG_IDX_W-1:0]   vreg_idx_t; // Vector register number
	typedef logic [LANE_IDX_W-1:0]   lane_idx_t; // Lane number

endpackage
